// File: sources.f
video_pkg.sv
stereo_pkg.sv
rgb_to_gray.sv
view_unfold.sv
disp_search.sv
view_select.sv
stereovision.sv
stereovision_props.sv
stereovision_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module stereovision_tb -o stereovision_sim
out=$(./obj_dir/stereovision_sim)
echo "$out"
if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
else
  exit 1
fi

// File: stereovision_tb.sv
`timescale 1ns/1ps

module stereovision_tb
  import video_pkg::*;
  import stereo_pkg::*;
;

  localparam int          LINE_MAX        = 16;
  localparam int          LATENCY         = 4;
  localparam int          NUM_ROWS        = 7;
  localparam int          WATCHDOG_CYCLES = NUM_ROWS * 40 * 2 + 200;
  localparam logic [31:0] SEED            = 32'heade8734;

  // one line per row, same sel rows run back to back
  typedef struct packed {
    view_sel_t  sel;
    logic [2:0] shift;
    logic [4:0] len;
    logic       gap;
    logic       sof;
    logic [2:0] exp_disp;
  } row_t;

  // what one output beat must look like
  typedef struct packed {
    logic [7:0] pix;
    logic       tuser;
    logic       tlast;
    logic       interior;
    logic [7:0] interior_pix;
    int         cyc;
  } exp_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{VIEW_GRAY_L, 3'd2, 5'd16, 1'b0, 1'b1, 3'd2},
    '{VIEW_GRAY_R, 3'd3, 5'd16, 1'b1, 1'b1, 3'd3},
    '{VIEW_DISP_L, 3'd0, 5'd16, 1'b0, 1'b1, 3'd0},
    '{VIEW_DISP_L, 3'd5, 5'd16, 1'b1, 1'b0, 3'd5},
    '{VIEW_DISP_L, 3'd7, 5'd16, 1'b0, 1'b0, 3'd7},
    '{VIEW_DISP_R, 3'd4, 5'd16, 1'b0, 1'b1, 3'd4},
    '{VIEW_DISP_R, 3'd6, 5'd16, 1'b1, 1'b0, 3'd6}
  };

  logic      aclk = 1'b0;
  logic      rst;
  rgb_t      in_pix;
  beat_t     in_beat;
  view_sel_t view_sel;
  rgb_t      out_pix;
  beat_t     out_beat;

  logic [31:0] rng;
  int          cyc = 0;
  int          pair_count = 0;
  int          out_count = 0;
  int          mismatch_errs = 0;
  int          protocol_errs = 0;
  int          count_errs = 0;
  // texture runs past the line end so the right view can shift into it
  rgb_t        tex [LINE_MAX + MAX_DISP];
  int          gl [LINE_MAX];
  int          gr [LINE_MAX];
  exp_t        exp_q [$];
  exp_t        got;

  stereovision dut_i (
    .aclk     (aclk),
    .rst      (rst),
    .in_pix   (in_pix),
    .in_beat  (in_beat),
    .view_sel (view_sel),
    .out_pix  (out_pix),
    .out_beat (out_beat)
  );

  always #4 aclk = ~aclk;

  always @(posedge aclk) begin
    cyc <= cyc + 1;
  end

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // weighted sum, weights add to 256
  function automatic int luma(input rgb_t p);
    return (int'(LUMA_R) * int'(p.r) + int'(LUMA_G) * int'(p.g)
            + int'(LUMA_B) * int'(p.b)) >> 8;
  endfunction

  function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
  endfunction

  // before the first pair of the line reads as zero
  function automatic int get_l(input int i);
    if (i < 0) begin
      return 0;
    end
    return gl[i];
  endfunction

  function automatic int get_r(input int i);
    if (i < 0) begin
      return 0;
    end
    return gr[i];
  endfunction

  // left window ending at k against right windows ending at k-d
  function automatic int ref_disp_left(input int k);
    int best;
    int best_cost;
    int c;
    best = 0;
    best_cost = 1 << 30;
    for (int d = 0; d < MAX_DISP; d++) begin
      c = 0;
      for (int j = 0; j < CNTX_SIZE; j++) begin
        c += abs_int(get_l(k - j) - get_r(k - d - j));
      end
      // first minimum wins
      if (c < best_cost) begin
        best_cost = c;
        best = d;
      end
    end
    return best;
  endfunction

  // right window ending at k-7 against left windows ending at k-7+d
  function automatic int ref_disp_right(input int k);
    int best;
    int best_cost;
    int c;
    int m;
    best = 0;
    best_cost = 1 << 30;
    m = k - (MAX_DISP - 1);
    for (int d = 0; d < MAX_DISP; d++) begin
      c = 0;
      for (int j = 0; j < CNTX_SIZE; j++) begin
        c += abs_int(get_r(m - j) - get_l(m + d - j));
      end
      if (c < best_cost) begin
        best_cost = c;
        best = d;
      end
    end
    return best;
  endfunction

  function automatic logic [7:0] expected_pix(input view_sel_t sel, input int k);
    case (sel)
      VIEW_GRAY_L: return 8'(gl[k]);
      VIEW_GRAY_R: return 8'(gr[k]);
      VIEW_DISP_L: return 8'(ref_disp_left(k) * DISP_SCALE);
      VIEW_DISP_R: return 8'(ref_disp_right(k) * DISP_SCALE);
      default:     return 8'(gl[k]);
    endcase
  endfunction

  // random left texture, right view is the same texture moved by s
  task automatic build_line(input int s);
    for (int i = 0; i < LINE_MAX + MAX_DISP; i++) begin
      rng = lcg_next(rng);
      tex[i] = rng[31:8];
    end
    for (int k = 0; k < LINE_MAX; k++) begin
      gl[k] = luma(tex[k]);
      gr[k] = luma(tex[k + s]);
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  task automatic drive_beat(input rgb_t pix, input logic tuser, input logic tlast);
    @(posedge aclk);
    #1;
    in_pix  = pix;
    in_beat = '{valid: 1'b1, tuser: tuser, tlast: tlast};
  endtask

  task automatic drive_idle();
    @(posedge aclk);
    #1;
    in_beat = '0;
  endtask

  // wait for every queued pair to come out
  task automatic drain_pipe();
    drive_idle();
    while (exp_q.size() != 0) begin
      @(posedge aclk);
      #1;
    end
  endtask

  task automatic send_line(input row_t row);
    exp_t e;
    int   s;
    int   len;
    s = int'(row.shift);
    len = int'(row.len);
    for (int k = 0; k < len; k++) begin
      rng = lcg_next(rng);
      if (row.gap && rng[20]) begin
        drive_idle();
      end
      drive_beat(tex[k], row.sof && (k == 0), 1'b0);
      rng = lcg_next(rng);
      if (row.gap && rng[20]) begin
        drive_idle();
      end
      drive_beat(tex[k + s], 1'b0, k == len - 1);
      // expectation tagged with the drive cycle of the right beat
      e.pix = expected_pix(row.sel, k);
      e.tuser = row.sof && (k == 0);
      e.tlast = (k == len - 1);
      e.interior = (row.sel == VIEW_DISP_L && k >= s + CNTX_SIZE - 1)
                || (row.sel == VIEW_DISP_R && k >= MAX_DISP + CNTX_SIZE - 2);
      e.interior_pix = 8'(int'(row.exp_disp) * DISP_SCALE);
      e.cyc = cyc;
      exp_q.push_back(e);
      pair_count++;
    end
  endtask

  // ----------------------------------------------------------------------
  // output monitor
  // ----------------------------------------------------------------------

  task automatic report_mismatch(input string name, input int exp, input int act);
    mismatch_errs++;
    $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, act);
  endtask

  // mid cycle, well away from the edge that updates the outputs
  always @(negedge aclk) begin
    if (!rst) begin
      if (!out_beat.valid && (out_beat.tuser || out_beat.tlast)) begin
        protocol_errs++;
        $display("%0t: output tuser or tlast seen without output valid", $time);
      end
      if (out_beat.valid) begin
        out_count++;
        if (exp_q.size() == 0) begin
          protocol_errs++;
          $display("%0t: output beat seen while no pair was pending", $time);
        end else begin
          got = exp_q.pop_front();
          if (out_pix.r != got.pix) report_mismatch("out_pix.r", int'(got.pix), int'(out_pix.r));
          if (out_pix.g != got.pix) report_mismatch("out_pix.g", int'(got.pix), int'(out_pix.g));
          if (out_pix.b != got.pix) report_mismatch("out_pix.b", int'(got.pix), int'(out_pix.b));
          if (got.interior && out_pix.r != got.interior_pix) begin
            report_mismatch("out_pix.r interior", int'(got.interior_pix), int'(out_pix.r));
          end
          if (out_beat.tuser != got.tuser) begin
            report_mismatch("out_beat.tuser", int'(got.tuser), int'(out_beat.tuser));
          end
          if (out_beat.tlast != got.tlast) begin
            report_mismatch("out_beat.tlast", int'(got.tlast), int'(out_beat.tlast));
          end
          // cycle of arrival vs drive cycle plus latency
          if (cyc != got.cyc + LATENCY) begin
            report_mismatch("out_beat.valid cycle", got.cyc + LATENCY, cyc);
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    row_t row;
    rst      = 1'b1;
    in_pix   = '0;
    in_beat  = '0;
    view_sel = VIEW_GRAY_L;
    rng      = SEED;
    repeat (16) @(posedge aclk);
    #1;
    rst = 1'b0;
    // quiet stretch, any output here is flagged by the monitor
    repeat (20) @(posedge aclk);
    #1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row = ROWS[r];
      // view_sel only moves with the pipe empty
      if (row.sel != view_sel) begin
        drain_pipe();
        view_sel = row.sel;
      end
      build_line(int'(row.shift));
      send_line(row);
    end
    drain_pipe();
    repeat (8) @(posedge aclk);
    if (out_count != pair_count) begin
      count_errs++;
      $display("output beat count %0d does not match pair count %0d", out_count, pair_count);
    end
    $display("errors: %0d mismatch, %0d protocol, %0d count",
             mismatch_errs, protocol_errs, count_errs);
    if (mismatch_errs + protocol_errs + count_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // bounded by the table length
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("watchdog expired after %0d cycles with %0d pairs still pending",
             WATCHDOG_CYCLES, exp_q.size());
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: stereovision_props.sv
`timescale 1ns/1ps

module stereovision_props
  import video_pkg::*;
(
  input logic  aclk,
  input logic  rst,
  input beat_t in_beat,
  input beat_t out_beat
);

  // own copy of the pair phase, seen from the input side
  logic in_phase;
  logic in_right;

  always_ff @(posedge aclk) begin
    if (rst) begin
      in_phase <= 1'b0;
    end else if (in_beat.valid) begin
      in_phase <= ~in_phase;
    end
  end

  assign in_right = in_beat.valid & in_phase;

  // ----------------------------------------------------------------------
  // output strobes
  // ----------------------------------------------------------------------

  // luma, unfold, search, select, one register each
  a_out_after_right: assert property (
    @(posedge aclk) disable iff (rst)
    out_beat.valid |-> $past(in_right, 4)
  ) else $error("output beat without a right input beat four cycles earlier");

  a_flags_need_valid: assert property (
    @(posedge aclk) disable iff (rst)
    (out_beat.tuser || out_beat.tlast) |-> out_beat.valid
  ) else $error("output tuser or tlast raised without output valid");

  // one cycle into reset the output register is cleared
  a_quiet_in_reset: assert property (
    @(posedge aclk)
    (rst && $past(rst)) |-> !out_beat.valid
  ) else $error("output valid while reset is held");

endmodule

bind stereovision stereovision_props props_i (
  .aclk     (aclk),
  .rst      (rst),
  .in_beat  (in_beat),
  .out_beat (out_beat)
);

// File: stereovision.sv
`timescale 1ns/1ps

module stereovision
  import video_pkg::*;
  import stereo_pkg::*;
(
  input  logic      aclk,
  input  logic      rst,
  input  rgb_t      in_pix,
  input  beat_t     in_beat,
  input  view_sel_t view_sel,
  output rgb_t      out_pix,
  output beat_t     out_beat
);

  // ----------------------------------------------------------------------
  // stage wires
  // ----------------------------------------------------------------------

  pixel_t     gray;
  beat_t      gray_beat;
  match_req_t req_l;
  match_req_t req_r;
  pair_t      pair;
  logic       req_valid;
  disp_t      disp_l;
  disp_t      disp_r;
  logic       disp_valid_l;

  // luma, one cycle
  rgb_to_gray gray_i (
    .aclk      (aclk),
    .rst       (rst),
    .in_pix    (in_pix),
    .in_beat   (in_beat),
    .gray      (gray),
    .gray_beat (gray_beat)
  );

  // left/right split and windows
  view_unfold unfold_i (
    .aclk      (aclk),
    .rst       (rst),
    .gray      (gray),
    .gray_beat (gray_beat),
    .req_l     (req_l),
    .req_r     (req_r),
    .pair      (pair),
    .req_valid (req_valid)
  );

  // left referenced matcher
  disp_search search_l_i (
    .aclk       (aclk),
    .rst        (rst),
    .req        (req_l),
    .req_valid  (req_valid),
    .disp       (disp_l),
    .disp_valid (disp_valid_l)
  );

  // right referenced matcher, same strobe timing as the left one
  disp_search search_r_i (
    .aclk       (aclk),
    .rst        (rst),
    .req        (req_r),
    .req_valid  (req_valid),
    .disp       (disp_r),
    .disp_valid ()
  );

  view_select select_i (
    .aclk       (aclk),
    .rst        (rst),
    .view_sel   (view_sel),
    .pair       (pair),
    .disp_l     (disp_l),
    .disp_r     (disp_r),
    .disp_valid (disp_valid_l),
    .out_pix    (out_pix),
    .out_beat   (out_beat)
  );

endmodule

// File: view_select.sv
`timescale 1ns/1ps

module view_select
  import video_pkg::*;
  import stereo_pkg::*;
(
  input  logic      aclk,
  input  logic      rst,
  input  view_sel_t view_sel,
  input  pair_t     pair,
  input  disp_t     disp_l,
  input  disp_t     disp_r,
  input  logic      disp_valid,
  output rgb_t      out_pix,
  output beat_t     out_beat
);

  // pair delayed one stage to sit next to the matcher results
  pixel_t left_q;
  pixel_t right_q;
  beat_t  beat_q;
  pixel_t shown;

  always_ff @(posedge aclk) begin
    if (pair.beat.valid) begin
      left_q  <= pair.left;
      right_q <= pair.right;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      beat_q <= '0;
    end else begin
      beat_q <= pair.beat;
    end
  end

  // ----------------------------------------------------------------------
  // view mux
  // ----------------------------------------------------------------------

  always_comb begin
    case (view_sel)
      VIEW_GRAY_L: shown = left_q;
      VIEW_GRAY_R: shown = right_q;
      // scaled up so small disparities are visible
      VIEW_DISP_L: shown = pixel_t'(disp_l * DISP_SCALE);
      VIEW_DISP_R: shown = pixel_t'(disp_r * DISP_SCALE);
      default:     shown = left_q;
    endcase
  end

  // gray goes out on all three channels
  always_ff @(posedge aclk) begin
    if (disp_valid) begin
      out_pix <= '{r: shown, g: shown, b: shown};
    end
  end

  // flags only ever ride on a valid output beat
  always_ff @(posedge aclk) begin
    if (rst) begin
      out_beat <= '0;
    end else begin
      out_beat <= '{valid: disp_valid,
                    tuser: disp_valid & beat_q.tuser,
                    tlast: disp_valid & beat_q.tlast};
    end
  end

endmodule

// File: disp_search.sv
`timescale 1ns/1ps

module disp_search
  import video_pkg::*;
  import stereo_pkg::*;
(
  input  logic       aclk,
  input  logic       rst,
  input  match_req_t req,
  input  logic       req_valid,
  output disp_t      disp,
  output logic       disp_valid
);

  logic [COST_W-1:0] cost [MAX_DISP];
  logic [COST_W-1:0] best_cost;
  disp_t             best_disp;

  // unsigned distance of two gray values
  function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
    return (a > b) ? a - b : b - a;
  endfunction

  // ----------------------------------------------------------------------
  // SAD per disparity
  // ----------------------------------------------------------------------

  always_comb begin
    for (int d = 0; d < MAX_DISP; d++) begin
      cost[d] = '0;
      for (int j = 0; j < CNTX_SIZE; j++) begin
        cost[d] = cost[d] + COST_W'(abs_diff(req.base[j], req.cand[d][j]));
      end
    end
  end

  // ----------------------------------------------------------------------
  // minimum search
  // ----------------------------------------------------------------------

  // strict compare, so a tie keeps the lower disparity
  always_comb begin
    best_cost = cost[0];
    best_disp = '0;
    for (int d = 1; d < MAX_DISP; d++) begin
      if (cost[d] < best_cost) begin
        best_cost = cost[d];
        best_disp = DISP_W'(d);
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (req_valid) begin
      disp <= best_disp;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      disp_valid <= 1'b0;
    end else begin
      disp_valid <= req_valid;
    end
  end

endmodule

// File: view_unfold.sv
`timescale 1ns/1ps

module view_unfold
  import video_pkg::*;
  import stereo_pkg::*;
(
  input  logic       aclk,
  input  logic       rst,
  input  pixel_t     gray,
  input  beat_t      gray_beat,
  output match_req_t req_l,
  output match_req_t req_r,
  output pair_t      pair,
  output logic       req_valid
);

  // 0 expects left beat, 1 expects right beat
  logic   phase;
  logic   right_beat;
  // left pixel parked until its right partner shows up
  pixel_t held_pix;
  logic   held_tuser;
  // index 0 is the newest pair of the line
  pixel_t [HIST_LEN-1:0] hist_l;
  pixel_t [HIST_LEN-1:0] hist_r;
  pixel_t [HIST_LEN-1:0] next_l;
  pixel_t [HIST_LEN-1:0] next_r;
  match_req_t asm_l;
  match_req_t asm_r;
  pixel_t pair_left;
  pixel_t pair_right;
  beat_t  pair_beat;

  assign right_beat = gray_beat.valid & phase;

  // histories as they look once this right beat is in
  assign next_l = {hist_l[HIST_LEN-2:0], held_pix};
  assign next_r = {hist_r[HIST_LEN-2:0], gray};

  // ----------------------------------------------------------------------
  // phase and left holding
  // ----------------------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (rst) begin
      phase      <= 1'b0;
      held_tuser <= 1'b0;
    end else if (gray_beat.valid) begin
      phase <= ~phase;
      if (!phase) begin
        held_tuser <= gray_beat.tuser;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (gray_beat.valid && !phase) begin
      held_pix <= gray;
    end
  end

  // ----------------------------------------------------------------------
  // line histories
  // ----------------------------------------------------------------------

  // cleared at end of line so the next line starts on zero padding
  always_ff @(posedge aclk) begin
    if (rst) begin
      hist_l <= '0;
      hist_r <= '0;
    end else if (right_beat) begin
      hist_l <= gray_beat.tlast ? '0 : next_l;
      hist_r <= gray_beat.tlast ? '0 : next_r;
    end
  end

  // ----------------------------------------------------------------------
  // window building
  // ----------------------------------------------------------------------

  always_comb begin
    for (int j = 0; j < CNTX_SIZE; j++) begin
      // left ref: window ending at k
      asm_l.base[j] = next_l[j];
      // right ref: window ending at k-7
      asm_r.base[j] = next_r[MAX_DISP-1+j];
      for (int d = 0; d < MAX_DISP; d++) begin
        // right window ending at k-d
        asm_l.cand[d][j] = next_r[d+j];
        // left window ending at k-7+d
        asm_r.cand[d][j] = next_l[MAX_DISP-1-d+j];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (right_beat) begin
      req_l      <= asm_l;
      req_r      <= asm_r;
      pair_left  <= next_l[0];
      pair_right <= gray;
    end
  end

  // pair strobes, tuser from the left beat and tlast from the right
  always_ff @(posedge aclk) begin
    if (rst) begin
      pair_beat <= '0;
    end else begin
      pair_beat <= '{valid: right_beat,
                     tuser: right_beat & held_tuser,
                     tlast: right_beat & gray_beat.tlast};
    end
  end

  assign req_valid = pair_beat.valid;
  assign pair      = '{left: pair_left, right: pair_right, beat: pair_beat};

endmodule

// File: rgb_to_gray.sv
`timescale 1ns/1ps

module rgb_to_gray
  import video_pkg::*;
(
  input  logic   aclk,
  input  logic   rst,
  input  rgb_t   in_pix,
  input  beat_t  in_beat,
  output pixel_t gray,
  output beat_t  gray_beat
);

  // full weighted sum, 16 bits hold 255 x 256
  logic [2*DATA_WIDTH-1:0] luma_sum;

  // ----------------------------------------------------------------------
  // weighted luma
  // ----------------------------------------------------------------------

  // products taken at the full sum width
  always_comb begin
    luma_sum = (2*DATA_WIDTH)'(LUMA_R) * (2*DATA_WIDTH)'(in_pix.r)
             + (2*DATA_WIDTH)'(LUMA_G) * (2*DATA_WIDTH)'(in_pix.g)
             + (2*DATA_WIDTH)'(LUMA_B) * (2*DATA_WIDTH)'(in_pix.b);
  end

  // gray value only updated on accepted beats
  always_ff @(posedge aclk) begin
    if (in_beat.valid) begin
      // drop the low byte
      gray <= luma_sum[2*DATA_WIDTH-1:DATA_WIDTH];
    end
  end

  // strobes follow the pixel by one cycle
  always_ff @(posedge aclk) begin
    if (rst) begin
      gray_beat <= '0;
    end else begin
      gray_beat <= in_beat;
    end
  end

endmodule

// File: stereo_pkg.sv
package stereo_pkg;

  import video_pkg::*;

  // ----------------------------------------------------------------------
  // matching geometry
  // ----------------------------------------------------------------------

  // disparities searched per pixel
  localparam int MAX_DISP   = 8;
  // horizontal window width
  localparam int CNTX_SIZE  = 3;
  // pixels kept per line history
  localparam int HIST_LEN   = MAX_DISP + CNTX_SIZE - 1;
  localparam int DISP_W     = 3;
  // 3 x 255 = 765 fits in 10 bits
  localparam int COST_W     = 10;
  // 7 x 32 = 224, spreads disparity over the 8-bit range
  localparam int DISP_SCALE = 32;

  // ----------------------------------------------------------------------
  // matching types
  // ----------------------------------------------------------------------

  // entry j is the pixel j positions before the window end
  typedef pixel_t [CNTX_SIZE-1:0] window_t;
  // entry d is the candidate window for disparity d
  typedef window_t [MAX_DISP-1:0] cand_t;
  typedef logic [DISP_W-1:0] disp_t;

  typedef struct packed {
    window_t base;
    cand_t   cand;
  } match_req_t;

  typedef struct packed {
    pixel_t left;
    pixel_t right;
    beat_t  beat;
  } pair_t;

endpackage

// File: video_pkg.sv
package video_pkg;

  // ----------------------------------------------------------------------
  // stream side constants
  // ----------------------------------------------------------------------

  // bits per colour channel, also per gray pixel
  localparam int DATA_WIDTH = 8;

  // luma weights, sum is 256 so a shift by 8 normalises
  localparam logic [DATA_WIDTH-1:0] LUMA_R = 8'd77;
  localparam logic [DATA_WIDTH-1:0] LUMA_G = 8'd150;
  localparam logic [DATA_WIDTH-1:0] LUMA_B = 8'd29;

  // ----------------------------------------------------------------------
  // stream side types
  // ----------------------------------------------------------------------

  typedef logic [DATA_WIDTH-1:0] pixel_t;

  typedef struct packed {
    pixel_t r;
    pixel_t g;
    pixel_t b;
  } rgb_t;

  // framing strobes of one beat
  // tuser marks start of frame, tlast end of line
  typedef struct packed {
    logic valid;
    logic tuser;
    logic tlast;
  } beat_t;

  // what the output stream shows
  typedef enum logic [1:0] {
    VIEW_GRAY_L = 2'd0,
    VIEW_GRAY_R = 2'd1,
    VIEW_DISP_L = 2'd2,
    VIEW_DISP_R = 2'd3
  } view_sel_t;

endpackage
